// ==== Bender.yml ====
package:
  name: ps2_keyboard_rx

sources:
  - include_dirs:
      - source
    files:
      - source/ps2_pkg.sv
      - source/key_event_if.sv
      - source/ps2_frame_receiver.sv
      - source/key_decoder.sv
      - source/key_output_buffer.sv
      - source/ps2_keyboard_rx.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/ps2_clock_gen.sv
      - tb/ps2_keyboard_asserts.sv
      - tb/ps2_keyboard_tb.sv

// ==== source/key_decoder.sv ====
//----------------------------------------------------------
// Key decoder
// E0/F0 prefix flags, shift and caps lock state,
// scan code to ASCII lookup and event register
//----------------------------------------------------------
`timescale 1ns/1ps
`include "ps2_defines.svh"

module key_decoder (
  input  logic                clk,
  input  logic                reset,
  input  logic                code_valid,
  input  ps2_pkg::scan_code_t scan_code,
  key_event_if.source         evt,
  output logic                shift_key_on,
  output logic                caps_lock
);

  logic hold_extended;   // E0 seen, waiting for the key code
  logic hold_released;   // F0 seen, waiting for the key code
  logic left_shift;
  logic right_shift;
  logic is_prefix;
  logic key_code;        // Real key code this cycle

  // Letters follow shift or caps and digits exist only unshifted
  function automatic ps2_pkg::ascii_t to_ascii(input ps2_pkg::scan_code_t code,
                                               input logic shift,
                                               input logic caps);
    ps2_pkg::ascii_t letter;
    ps2_pkg::ascii_t other;
    letter = 7'h00;
    other  = 7'h00;
    case (code)
      8'h1c: letter = 7'h61;  // a
      8'h32: letter = 7'h62;  // b
      8'h21: letter = 7'h63;
      8'h23: letter = 7'h64;
      8'h24: letter = 7'h65;  // e
      8'h2b: letter = 7'h66;
      8'h34: letter = 7'h67;
      8'h33: letter = 7'h68;
      8'h43: letter = 7'h69;  // i
      8'h3b: letter = 7'h6a;
      8'h42: letter = 7'h6b;
      8'h4b: letter = 7'h6c;
      8'h3a: letter = 7'h6d;  // m
      8'h31: letter = 7'h6e;
      8'h44: letter = 7'h6f;
      8'h4d: letter = 7'h70;
      8'h15: letter = 7'h71;  // q
      8'h2d: letter = 7'h72;
      8'h1b: letter = 7'h73;
      8'h2c: letter = 7'h74;
      8'h3c: letter = 7'h75;  // u
      8'h2a: letter = 7'h76;
      8'h1d: letter = 7'h77;
      8'h22: letter = 7'h78;
      8'h35: letter = 7'h79;
      8'h1a: letter = 7'h7a;  // z
      8'h45: other  = shift ? 7'h00 : 7'h30;  // 0
      8'h16: other  = shift ? 7'h00 : 7'h31;
      8'h1e: other  = shift ? 7'h00 : 7'h32;
      8'h26: other  = shift ? 7'h00 : 7'h33;
      8'h25: other  = shift ? 7'h00 : 7'h34;
      8'h2e: other  = shift ? 7'h00 : 7'h35;  // 5
      8'h36: other  = shift ? 7'h00 : 7'h36;
      8'h3d: other  = shift ? 7'h00 : 7'h37;
      8'h3e: other  = shift ? 7'h00 : 7'h38;
      8'h46: other  = shift ? 7'h00 : 7'h39;  // 9
      8'h29: other  = 7'h20;  // Space
      8'h5a: other  = 7'h0d;  // Enter
      8'h66: other  = 7'h08;  // Backspace
      8'h76: other  = 7'h1b;  // Escape
      default: other = 7'h00;
    endcase
    // Upper case sits 20h below lower case
    if (letter != 7'h00)
      return (shift || caps) ? (letter - 7'h20) : letter;
    else
      return other;
  endfunction

  assign is_prefix = (scan_code == `PS2_EXTEND_CODE) || (scan_code == `PS2_RELEASE_CODE);
  assign key_code  = code_valid && !is_prefix;

  //----------------------------------------------------------
  // Prefix flags, modifier state and event strobe
  //----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
      left_shift    <= 1'b0;
      right_shift   <= 1'b0;
      caps_lock     <= 1'b0;
      evt.key_valid <= 1'b0;
    end
    else
    begin
      evt.key_valid <= key_code;
      if (code_valid && (scan_code == `PS2_EXTEND_CODE))
        hold_extended <= 1'b1;
      if (code_valid && (scan_code == `PS2_RELEASE_CODE))
        hold_released <= 1'b1;
      if (key_code)
      begin
        hold_extended <= 1'b0;  // Flags go out with this event
        hold_released <= 1'b0;
        if (scan_code == `PS2_LEFT_SHIFT)
          left_shift <= !hold_released;
        if (scan_code == `PS2_RIGHT_SHIFT)
          right_shift <= !hold_released;
        if ((scan_code == `PS2_CAPS_LOCK) && !hold_released)
          caps_lock <= !caps_lock;  // Toggle on press only
      end
    end
  end

  // Payload uses modifier state from before this code
  always_ff @(posedge clk)
  begin
    if (key_code)
    begin
      evt.extended  <= hold_extended;
      evt.released  <= hold_released;
      evt.scan_code <= scan_code;
      evt.ascii     <= to_ascii(scan_code, shift_key_on, caps_lock);
    end
  end

  assign shift_key_on = left_shift || right_shift;

endmodule

// ==== source/key_event_if.sv ====
//----------------------------------------------------------
// Key event link from the decoder to the output buffer
// One-cycle valid pulse with the event payload
//----------------------------------------------------------
`timescale 1ns/1ps

interface key_event_if;

  logic                 key_valid;  // One cycle per key event
  logic                 extended;   // E0 prefix came before the code
  logic                 released;   // F0 prefix came before the code
  ps2_pkg::scan_code_t  scan_code;
  ps2_pkg::ascii_t      ascii;

  // Decoder side
  modport source (
    output key_valid, extended, released, scan_code, ascii
  );

  // Buffer side without back-pressure
  modport sink (
    input  key_valid, extended, released, scan_code, ascii
  );

endinterface

// ==== source/key_output_buffer.sv ====
//----------------------------------------------------------
// Key output buffer
// Holds the latest key event and data-ready for the host
//----------------------------------------------------------
`timescale 1ns/1ps

module key_output_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                rx_read,        // Host acknowledge
  key_event_if.sink           evt,
  output logic                rx_extended,
  output logic                rx_released,
  output ps2_pkg::scan_code_t rx_scan_code,
  output ps2_pkg::ascii_t     rx_ascii,
  output logic                rx_data_ready
);

  ps2_pkg::ready_state_e state;

  // Newest event always wins, even if unread
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
      rx_scan_code <= '0;
      rx_ascii     <= '0;
    end
    else if (evt.key_valid)
    begin
      rx_extended  <= evt.extended;
      rx_released  <= evt.released;
      rx_scan_code <= evt.scan_code;
      rx_ascii     <= evt.ascii;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::buf_empty;
    else if (evt.key_valid)
      state <= ps2_pkg::buf_ready;  // Overwrite keeps it ready
    else if (rx_read)
      state <= ps2_pkg::buf_empty;
  end

  assign rx_data_ready = (state == ps2_pkg::buf_ready);

endmodule

// ==== source/ps2_defines.svh ====
//----------------------------------------------------------
// Frame and timing constants of the PS/2 receiver
// Special scan codes for prefixes, shift and caps lock
//----------------------------------------------------------
`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

// Frame layout of start, 8 data bits, parity and stop
`define PS2_FRAME_BITS      11

// Idle line-clock watchdog of 60 us at 10 MHz
`define PS2_WATCHDOG_CYCLES 600
`define PS2_WATCHDOG_BITS   10

// Prefix codes
`define PS2_EXTEND_CODE     8'hE0  // Extended key follows
`define PS2_RELEASE_CODE    8'hF0  // Key release follows

// Keys with state kept in the decoder
`define PS2_LEFT_SHIFT      8'h12
`define PS2_RIGHT_SHIFT     8'h59
`define PS2_CAPS_LOCK       8'h58

`endif

// ==== source/ps2_frame_receiver.sv ====
//----------------------------------------------------------
// PS/2 frame receiver
// Line synchronizers, line-clock FSM, shift register,
// bit counter and idle watchdog
//----------------------------------------------------------
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_frame_receiver (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  output logic                code_valid,   // One cycle per full frame
  output ps2_pkg::scan_code_t scan_code
);

  logic                       ps2_clk_s;     // Synchronized line clock
  logic                       ps2_data_s;    // Synchronized line data
  ps2_pkg::rx_state_e         state;
  ps2_pkg::rx_state_e         next_state;
  ps2_pkg::frame_t            frame_q;
  ps2_pkg::bit_count_t        bit_count;
  ps2_pkg::watchdog_count_t   watchdog_count;
  logic                       watchdog_done;
  logic                       in_marker;

  // Single sync stage on both lines
  always_ff @(posedge clk)
  begin
    ps2_clk_s  <= ps2_clk;
    ps2_data_s <= ps2_data;
  end

  //----------------------------------------------------------
  // Line-clock FSM
  //----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::rx_clk_high;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    unique case (state)
      ps2_pkg::rx_clk_high:  if (!ps2_clk_s) next_state = ps2_pkg::rx_fall_mark;
      ps2_pkg::rx_fall_mark: next_state = ps2_pkg::rx_clk_low;
      ps2_pkg::rx_clk_low:   if (ps2_clk_s) next_state = ps2_pkg::rx_rise_mark;
      ps2_pkg::rx_rise_mark: next_state = ps2_pkg::rx_clk_high;
    endcase
  end

  assign in_marker = (state == ps2_pkg::rx_fall_mark) || (state == ps2_pkg::rx_rise_mark);

  // LSB first, so new bits enter at the top
  always_ff @(posedge clk)
  begin
    if (state == ps2_pkg::rx_fall_mark)
      frame_q <= {ps2_data_s, frame_q[`PS2_FRAME_BITS-1:1]};
  end

  assign code_valid = (bit_count == ps2_pkg::bit_count_t'(`PS2_FRAME_BITS));
  assign scan_code  = frame_q[8:1];  // Drop start, parity and stop

  //----------------------------------------------------------
  // Bit counter and watchdog
  //----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || code_valid)
      bit_count <= '0;
    else if (watchdog_done && (state == ps2_pkg::rx_clk_high) && ps2_clk_s)
      bit_count <= '0;  // Partial frame dropped after a long idle line
    else if (state == ps2_pkg::rx_fall_mark)
      bit_count <= bit_count + 4'd1;
  end

  // Restarts on every line edge and saturates at the limit
  always_ff @(posedge clk)
  begin
    if (reset || in_marker)
      watchdog_count <= '0;
    else if (!watchdog_done)
      watchdog_count <= watchdog_count + 1'b1;
  end

  assign watchdog_done =
    (watchdog_count == ps2_pkg::watchdog_count_t'(`PS2_WATCHDOG_CYCLES));

endmodule

// ==== source/ps2_keyboard_rx.sv ====
//----------------------------------------------------------
// PS/2 keyboard receiver top level
// Frame receiver, key decoder and output buffer
//----------------------------------------------------------
`timescale 1ns/1ps

module ps2_keyboard_rx (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,          // Keyboard line clock
  input  logic                ps2_data,         // Keyboard line data
  input  logic                rx_read,
  output logic                rx_extended,
  output logic                rx_released,
  output logic                rx_shift_key_on,
  output ps2_pkg::scan_code_t rx_scan_code,
  output ps2_pkg::ascii_t     rx_ascii,
  output logic                rx_data_ready,
  output logic                caps_lock
);

  logic                code_valid;
  ps2_pkg::scan_code_t scan_code;

  key_event_if evt_if ();  // Decoder to buffer

  ps2_frame_receiver u_receiver (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .code_valid (code_valid),
    .scan_code  (scan_code)
  );

  key_decoder u_decoder (
    .clk          (clk),
    .reset        (reset),
    .code_valid   (code_valid),
    .scan_code    (scan_code),
    .evt          (evt_if.source),
    .shift_key_on (rx_shift_key_on),
    .caps_lock    (caps_lock)
  );

  key_output_buffer u_buffer (
    .clk           (clk),
    .reset         (reset),
    .rx_read       (rx_read),
    .evt           (evt_if.sink),
    .rx_extended   (rx_extended),
    .rx_released   (rx_released),
    .rx_scan_code  (rx_scan_code),
    .rx_ascii      (rx_ascii),
    .rx_data_ready (rx_data_ready)
  );

endmodule

// ==== source/ps2_pkg.sv ====
//----------------------------------------------------------
// Shared types of the PS/2 keyboard receiver
// Vector typedefs for codes, counters and the frame
// State enums of the receiver and the output buffer
//----------------------------------------------------------
`include "ps2_defines.svh"

package ps2_pkg;

  typedef logic [7:0]                        scan_code_t;       // Raw keyboard code
  typedef logic [6:0]                        ascii_t;           // 7-bit character
  typedef logic [`PS2_FRAME_BITS-1:0]        frame_t;           // Whole frame incl. framing
  typedef logic [3:0]                        bit_count_t;       // Bits seen in a frame
  typedef logic [`PS2_WATCHDOG_BITS-1:0]     watchdog_count_t;  // Idle line timer

  // Receiver follows the line clock and markers last one cycle
  typedef enum logic [1:0] {
    rx_clk_high  = 2'd0,  // Line clock idle or high
    rx_fall_mark = 2'd1,  // Falling edge seen, sample data
    rx_clk_low   = 2'd2,  // Line clock low
    rx_rise_mark = 2'd3   // Rising edge seen
  } rx_state_e;

  // Output buffer holds one event for the host
  typedef enum logic {
    buf_empty = 1'b0,
    buf_ready = 1'b1
  } ready_state_e;

endpackage

// ==== tb/ps2_clock_gen.sv ====
//----------------------------------------------------------
// Testbench clock and reset source
// 100 ns clk, reset high for the first 5 cycles
//----------------------------------------------------------
`timescale 1ns/1ps

module ps2_clock_gen (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;  // Released on a falling edge like other inputs
  end

  always #50 clk = ~clk;  // 10 MHz

endmodule

// ==== tb/ps2_keyboard_asserts.sv ====
//----------------------------------------------------------
// Concurrent checks on the receiver top level
// Reset value, ready hold until read, stable ascii output
//----------------------------------------------------------
`timescale 1ns/1ps

module ps2_keyboard_asserts (
  input logic            clk,
  input logic            reset,
  input logic            rx_read,
  input logic            rx_data_ready,
  input ps2_pkg::ascii_t rx_ascii,
  input logic            key_valid    // Decoder event strobe
);

  int failure_count = 0;  // Assertion failures so far

  // Buffer comes out of reset empty
  assert property (@(posedge clk) reset && $past(reset) |-> !rx_data_ready)
    else
    begin
      failure_count++;
      $error("rx_data_ready high during reset");
    end

  // Host must read before ready drops
  assert property (@(posedge clk) disable iff (reset)
                   rx_data_ready && !rx_read |=> rx_data_ready)
    else
    begin
      failure_count++;
      $error("rx_data_ready dropped without rx_read");
    end

  // Output character only moves with a new event
  assert property (@(posedge clk) disable iff (reset)
                   !key_valid |=> $stable(rx_ascii))
    else
    begin
      failure_count++;
      $error("rx_ascii changed without a key event");
    end

endmodule

bind ps2_keyboard_rx ps2_keyboard_asserts u_asserts (
  .clk           (clk),
  .reset         (reset),
  .rx_read       (rx_read),
  .rx_data_ready (rx_data_ready),
  .rx_ascii      (rx_ascii),
  .key_valid     (evt_if.key_valid)
);

// ==== tb/ps2_keyboard_tb.sv ====
//----------------------------------------------------------
// PS/2 keyboard receiver testbench
// Keyboard frame model, key state model, reference ASCII
// table, compare process and per-test report
//----------------------------------------------------------
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_keyboard_tb;

  typedef struct packed {
    logic                extended;
    logic                released;
    ps2_pkg::scan_code_t scan_code;
    ps2_pkg::ascii_t     ascii;
    logic                shift_on;   // Level after the event
    logic                caps;
  } key_expect_t;

  logic                clk;
  logic                reset;
  logic                ps2_clk;
  logic                ps2_data;
  logic                rx_read;
  logic                rx_extended;
  logic                rx_released;
  logic                rx_shift_key_on;
  logic                rx_data_ready;
  logic                caps_lock;
  ps2_pkg::scan_code_t rx_scan_code;
  ps2_pkg::ascii_t     rx_ascii;

  // Scan codes of a..z and 0..9 in character order
  localparam logic [0:25][7:0] letter_codes = {
    8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a,
    8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};
  localparam logic [0:9][7:0] digit_codes = {
    8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46};

  key_expect_t expected_q[$];  // Events still to be seen
  integer      seed;
  int          error_count;
  int          test_errors;    // error_count at test start
  int          tests_run;
  int          tests_failed;
  int          hold_cycles;    // Host delay before reading
  logic        hold_ext;       // Model of the prefix flags
  logic        hold_rel;
  logic        left_shift;
  logic        right_shift;
  logic        caps_model;

  ps2_clock_gen u_clock_gen (.clk(clk), .reset(reset));

  ps2_keyboard_rx DUT (
    .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data), .rx_read(rx_read),
    .rx_extended(rx_extended), .rx_released(rx_released), .rx_shift_key_on(rx_shift_key_on),
    .rx_scan_code(rx_scan_code), .rx_ascii(rx_ascii), .rx_data_ready(rx_data_ready),
    .caps_lock(caps_lock)
  );

  // Expected character for a code under the given modifiers
  function automatic ps2_pkg::ascii_t ref_ascii(input ps2_pkg::scan_code_t code,
                                                input logic shift, input logic caps);
    ps2_pkg::ascii_t result;
    int              i;
    result = 7'h00;
    for (i = 0; i < 26; i++)
      if (letter_codes[i] == code)
        result = ((shift || caps) ? 7'h41 : 7'h61) + i[6:0];
    for (i = 0; i < 10; i++)
      if ((digit_codes[i] == code) && !shift)
        result = 7'h30 + i[6:0];  // Shifted digits stay 00
    case (code)
      8'h29:   result = 7'h20;  // Space
      8'h5a:   result = 7'h0d;  // Enter
      8'h66:   result = 7'h08;  // Backspace
      8'h76:   result = 7'h1b;  // Escape
      default: ;
    endcase
    return result;
  endfunction

  // Start, data LSB first, odd parity, stop
  function automatic ps2_pkg::frame_t make_frame(input ps2_pkg::scan_code_t code);
    return {1'b1, ~^code, code, 1'b0};
  endfunction

  //----------------------------------------------------------
  // Compare tasks
  //----------------------------------------------------------
  task automatic check_code(input string name, input ps2_pkg::scan_code_t got,
                            input ps2_pkg::scan_code_t exp);
    if (got !== exp)
    begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_ascii(input string name, input ps2_pkg::ascii_t got,
                             input ps2_pkg::ascii_t exp);
    if (got !== exp)
    begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    error_count++;
  endtask

  //----------------------------------------------------------
  // Keyboard model with 8 cycles low and 8 high per bit
  //----------------------------------------------------------
  task automatic send_bits(input ps2_pkg::frame_t frame, input int count);
    int i;
    for (i = 0; i < count; i++)
    begin
      @(negedge clk);
      ps2_data = frame[i];  // Data settles while line clock is high
      repeat (3) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (8) @(negedge clk);
      ps2_clk = 1'b1;
      repeat (4) @(negedge clk);
    end
    ps2_data = 1'b1;
  endtask

  // Tracks prefixes and modifiers and queues the event a key makes
  task automatic model_code(input ps2_pkg::scan_code_t code);
    key_expect_t e;
    if (code == `PS2_EXTEND_CODE)
      hold_ext = 1'b1;
    else if (code == `PS2_RELEASE_CODE)
      hold_rel = 1'b1;
    else
    begin
      e.extended  = hold_ext;
      e.released  = hold_rel;
      e.scan_code = code;
      e.ascii     = ref_ascii(code, left_shift || right_shift, caps_model);  // State before
      if (code == `PS2_LEFT_SHIFT)
        left_shift = !hold_rel;
      if (code == `PS2_RIGHT_SHIFT)
        right_shift = !hold_rel;
      if ((code == `PS2_CAPS_LOCK) && !hold_rel)
        caps_model = !caps_model;
      e.shift_on = left_shift || right_shift;
      e.caps     = caps_model;
      expected_q.push_back(e);
      hold_ext = 1'b0;
      hold_rel = 1'b0;
    end
  endtask

  task automatic send_key(input ps2_pkg::scan_code_t code);
    send_bits(make_frame(code), `PS2_FRAME_BITS);
    model_code(code);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((expected_q.size() != 0) && (waited < 2000))
    begin
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0)
      report_timeout("expected key events were not all seen");
  endtask

  task automatic finish_test(input string name);
    wait_drained();
    tests_run++;
    if (error_count == test_errors)
      $display("Test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, error_count - test_errors);
    end
    test_errors = error_count;
  endtask

  //----------------------------------------------------------
  // Host side that checks each event and then reads it
  //----------------------------------------------------------
  initial
  begin : compare_events
    key_expect_t e;
    int          waited;
    forever
    begin
      @(negedge clk);
      if (expected_q.size() != 0)
      begin
        e      = expected_q[0];
        waited = 0;
        while (!rx_data_ready && (waited < 400))
        begin
          @(negedge clk);
          waited++;
        end
        if (!rx_data_ready)
          report_timeout("rx_data_ready never rose for an expected key event");
        else
        begin
          check_code("rx_scan_code", rx_scan_code, e.scan_code);
          check_ascii("rx_ascii", rx_ascii, e.ascii);
          check_flag("rx_extended", rx_extended, e.extended);
          check_flag("rx_released", rx_released, e.released);
          check_flag("rx_shift_key_on", rx_shift_key_on, e.shift_on);
          check_flag("caps_lock", caps_lock, e.caps);
          repeat (hold_cycles)
          begin
            @(negedge clk);
            check_flag("rx_data_ready", rx_data_ready, 1'b1);  // No read yet
          end
          rx_read = 1'b1;
          @(negedge clk);
          rx_read = 1'b0;
          waited  = 0;
          while (rx_data_ready && (waited < 20))
          begin
            @(negedge clk);
            waited++;
          end
          if (rx_data_ready)
            report_timeout("rx_data_ready did not drop after rx_read");
        end
        e = expected_q.pop_front();
      end
    end
  end

  // Hard stop on a hung run
  initial
  begin
    repeat (50000) @(posedge clk);
    $display("Simulation time limit reached, run stopped");
    $display("** FAIL **");
    $finish;
  end

  //----------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------
  initial
  begin : stimulus
    int       waited;
    int       n;
    integer   r;
    ps2_clk      = 1'b1;  // Idle lines
    ps2_data     = 1'b1;
    rx_read      = 1'b0;
    seed         = 32'hd73600ed;
    error_count  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    hold_cycles  = 0;
    hold_ext     = 1'b0;
    hold_rel     = 1'b0;
    left_shift   = 1'b0;
    right_shift  = 1'b0;
    caps_model   = 1'b0;
    waited       = 0;
    while (reset !== 1'b0 && (waited < 20))
    begin
      @(negedge clk);
      waited++;
    end
    if (reset !== 1'b0)
      report_timeout("reset was never released");

    for (n = 0; n < 12; n++)
    begin
      r = $random(seed);
      r = (r & 32'h7fffffff) % 36;  // 26 letters then 10 digits
      send_key((r < 26) ? letter_codes[r] : digit_codes[r - 26]);
    end
    finish_test("random letters and digits");

    send_key(`PS2_LEFT_SHIFT);
    send_key(8'h2d);  // r comes out as R
    send_key(`PS2_RELEASE_CODE);
    send_key(`PS2_LEFT_SHIFT);
    finish_test("shift press, letter, shift release");

    send_key(`PS2_CAPS_LOCK);
    send_key(8'h1c);
    send_key(`PS2_RELEASE_CODE);
    send_key(`PS2_CAPS_LOCK);  // Release leaves caps on
    send_key(8'h32);
    send_key(`PS2_CAPS_LOCK);
    send_key(8'h21);
    finish_test("caps lock toggle");

    send_key(`PS2_EXTEND_CODE);
    send_key(8'h75);  // Arrow up
    send_key(8'h24);
    finish_test("extended prefix");

    send_bits(make_frame(8'h1c), 4);  // Keyboard stops mid-frame
    repeat (`PS2_WATCHDOG_CYCLES + 100) @(negedge clk);
    check_flag("rx_data_ready", rx_data_ready, 1'b0);
    send_key(8'h3a);
    finish_test("watchdog after partial frame");

    hold_cycles = 40;
    send_key(8'h2c);
    wait_drained();
    hold_cycles = 0;
    finish_test("ready held until read");

    error_count += DUT.u_asserts.failure_count;  // Concurrent check failures
    $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/ps2_pkg.sv
source/key_event_if.sv
source/ps2_frame_receiver.sv
source/key_decoder.sv
source/key_output_buffer.sv
source/ps2_keyboard_rx.sv
tb/ps2_clock_gen.sv
tb/ps2_keyboard_asserts.sv
tb/ps2_keyboard_tb.sv
